// File: rd_fill.f
rtl/rd_fill_pkg.sv
rtl/fill_read_if.sv
rtl/rd_fill_sequencer.sv
rtl/fill_data_reader.sv
rtl/rd_fill_top.sv
tests/rd_fill_tb_models.sv
tests/rd_fill_tb.sv

// File: tests/rd_fill_testdata.txt
// Lines 1-8: memory image, 64 words. Then per test: csn cmd_code hdr_words trigger
// buffer_size channel post_trigger start_addr ready_pct, all hex; ffffffff ends the list
1a2b3c4d 5e6f7081 92a3b4c5 d6e7f809 0badf00d 13579bdf 2468ace0 fedcba98
01234567 89abcdef 76543210 f0e1d2c3 b4a59687 78695a4b 3c2d1e0f c0ffee11
deadbeef cafebabe 8badf00d 0ddba11a 55aa55aa aa55aa55 33cc33cc cc33cc33
0f0f0f0f f0f0f0f0 12121212 34343434 56565656 78787878 9a9a9a9a bcbcbcbc
a1b2c3d4 e5f60718 293a4b5c 6d7e8f90 11223344 55667788 99aabbcc ddeeff00
31415926 27182818 16180339 14142135 17320508 22360679 24494897 26457513
7fffffff 80000000 00000001 fffffffe 0000ffff ffff0000 00ff00ff ff00ff00
c3a5e1f7 5a3c96e1 e7c3a581 18243c5a 6699aa55 9966cc33 4b1e2d3c 87654321
00000001 0000a501 5 00000011 00000008 00000002 00000100 00000000 64
00000002 0000a501 5 00000011 00000008 00000002 00000100 00000000 32
00000003 0000a502 0 00000000 00000000 00000000 00000000 00000000 64
00000004 0000a502 1 00000022 00000000 00000000 00000000 00000000 3c
00000005 0000a503 5 00000033 00000000 00000001 00000020 00000010 64
00000006 0000a504 5 00000044 00000010 00000003 00000040 00000020 64
00000007 0000a504 5 00000044 00000010 00000003 00000040 00000020 28
00000008 0000a505 5 00000055 abcd0005 00000004 00000080 0000003a 46
ffffffff

// File: tests/rd_fill_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rd_fill_tb;

	// Memory image words, then nine fields per test
	localparam int IMAGE_WORDS = 64;
	localparam int FIELDS = 9;
	localparam int DATA_DEPTH = 512;
	localparam rd_fill_pkg::word_t END_MARK = 32'hffff_ffff;

	logic clk;
	logic rst;
	logic run;
	rd_fill_pkg::word_t csn;
	rd_fill_pkg::word_t cmd_code;
	logic tx_tready;
	rd_fill_pkg::word_t hdr_dout;
	logic hdr_empty;
	rd_fill_pkg::word_t mem_rdata;
	wire busy;
	wire done;
	wire tx_tvalid;
	rd_fill_pkg::word_t tx_tdata;
	wire tx_tlast;
	wire hdr_rd_en;
	rd_fill_pkg::addr_t mem_addr;

	rd_fill_pkg::word_t testdata [DATA_DEPTH];
	rd_fill_pkg::word_t rx_data [$];
	logic rx_last [$];
	logic collecting = 1'b0;
	logic got_last = 1'b0;
	int done_count = 0;
	int ready_pct = 100;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 1000000;

	rd_fill_top dut (
		.clk(clk),
		.rst(rst),
		.run(run),
		.csn(csn),
		.cmd_code(cmd_code),
		.busy(busy),
		.done(done),
		.tx_tvalid(tx_tvalid),
		.tx_tdata(tx_tdata),
		.tx_tlast(tx_tlast),
		.tx_tready(tx_tready),
		.hdr_dout(hdr_dout),
		.hdr_empty(hdr_empty),
		.hdr_rd_en(hdr_rd_en),
		.mem_addr(mem_addr),
		.mem_rdata(mem_rdata)
	);

	hdr_fifo_model u_hdr (
		.clk(clk),
		.rd_en(hdr_rd_en),
		.dout(hdr_dout),
		.empty(hdr_empty)
	);

	buffer_mem_model u_mem (
		.clk(clk),
		.addr(mem_addr),
		.rdata(mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Cycle limit comes from the test file, set before the first edge
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// Stream monitor, samples transfers on the edge where they happen
	always @(posedge clk) begin
		if (collecting) begin
			// done is checked before this edge's transfer is recorded
			if (done) begin
				done_count++;
				if (!got_last) begin
					$display("Error: done pulsed before the word marked last");
					errors++;
				end
			end
			if (tx_tvalid && tx_tready) begin
				rx_data.push_back(tx_tdata);
				rx_last.push_back(tx_tlast);
				if (tx_tlast) got_last = 1'b1;
			end
		end
	end

	task automatic check_word(input string name, input rd_fill_pkg::word_t got,
		input rd_fill_pkg::word_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_last(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// One falling edge, new random ready for the coming cycle
	task automatic step_cycle();
		@(negedge clk);
		tx_tready = ($urandom % 100) < ready_pct;
	endtask

	// Short packet unless both the trigger number and the buffer size were loaded
	function automatic int packet_length(input int base);
		rd_fill_pkg::word_t size_w;
		size_w = testdata[base+4];
		if (testdata[base+2] < 2) return 2;
		return 7 + int'(size_w[rd_fill_pkg::ADDR_W-1:0]);
	endfunction

	task automatic run_test(input int t, input int base);
		rd_fill_pkg::word_t expected [$];
		rd_fill_pkg::word_t sum;
		rd_fill_pkg::word_t size_w;
		rd_fill_pkg::addr_t a;
		int n_hdr;
		int size;
		int errors_before;
		errors_before = errors;
		n_hdr = testdata[base+2];
		size_w = testdata[base+4];
		size = size_w[rd_fill_pkg::ADDR_W-1:0];
		// Expected packet from the response rules
		expected.push_back(testdata[base]);
		if (n_hdr < 2) begin
			expected.push_back(~testdata[base+1]);
		end else begin
			expected.push_back(testdata[base+1]);
			for (int i = 3; i < 7; i++) expected.push_back(testdata[base+i]);
			sum = '0;
			for (int i = 0; i < size; i++) begin
				a = testdata[base+7][rd_fill_pkg::ADDR_W-1:0] + i;
				expected.push_back(testdata[a[5:0]]);
				sum = sum ^ testdata[a[5:0]];
			end
			expected.push_back(sum);
		end
		// Load the FIFO and present the command
		@(negedge clk);
		u_hdr.clear();
		for (int i = 0; i < n_hdr; i++) u_hdr.load(testdata[base+3+i]);
		csn = testdata[base];
		cmd_code = testdata[base+1];
		ready_pct = testdata[base+8];
		rx_data.delete();
		rx_last.delete();
		got_last = 1'b0;
		done_count = 0;
		collecting = 1'b1;
		run = 1'b1;
		while (!got_last || done_count == 0) step_cycle();
		// Two more cycles to catch a repeated done
		step_cycle();
		step_cycle();
		check_count("done pulses", done_count, 1);
		check_last("busy", busy, 1'b1);
		run = 1'b0;
		step_cycle();
		collecting = 1'b0;
		check_last("busy", busy, 1'b0);
		check_last("tx_tvalid", tx_tvalid, 1'b0);
		check_count("packet words", rx_data.size(), expected.size());
		for (int i = 0; i < rx_data.size() && i < expected.size(); i++) begin
			check_word($sformatf("tx_tdata[%0d]", i), rx_data[i], expected[i]);
			check_last($sformatf("tx_tlast[%0d]", i), rx_last[i], i == expected.size() - 1);
		end
		check_count("hdr_rd_en pops", u_hdr.pops, n_hdr);
		$display("Test %0d: %0d words, ready %0d%%, %s", t, expected.size(), ready_pct,
			(errors == errors_before) ? "ok" : "bad");
	endtask

	initial begin
		int n_tests;
		int total;
		int n_bad;
		int err_mark;
		void'($urandom(60));
		rst = 1'b1;
		run = 1'b0;
		csn = '0;
		cmd_code = '0;
		tx_tready = 1'b0;
		for (int i = 0; i < DATA_DEPTH; i++) testdata[i] = END_MARK;
		$readmemh("tests/rd_fill_testdata.txt", testdata);
		for (int i = 0; i < IMAGE_WORDS; i++) u_mem.load_word(i, testdata[i]);
		// Count tests up to the end marker and size the cycle limit
		n_tests = 0;
		total = 0;
		while (IMAGE_WORDS + FIELDS * (n_tests + 1) <= DATA_DEPTH &&
			testdata[IMAGE_WORDS + FIELDS * n_tests] !== END_MARK) begin
			total += packet_length(IMAGE_WORDS + FIELDS * n_tests) + 20;
			n_tests++;
		end
		cycle_limit = 16 + 8 * total;
		repeat (16) @(negedge clk);
		check_last("tx_tvalid", tx_tvalid, 1'b0);
		check_last("tx_tlast", tx_tlast, 1'b0);
		check_last("hdr_rd_en", hdr_rd_en, 1'b0);
		check_last("done", done, 1'b0);
		check_last("busy", busy, 1'b0);
		rst = 1'b0;
		n_bad = 0;
		for (int t = 0; t < n_tests; t++) begin
			err_mark = errors;
			run_test(t, IMAGE_WORDS + FIELDS * t);
			if (errors != err_mark) n_bad++;
		end
		$display("Summary: %0d tests, %0d ok, %0d bad, %0d check errors",
			n_tests, n_tests - n_bad, n_bad, errors);
		if (errors == 0 && n_tests > 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/rd_fill_tb_models.sv
`timescale 1ns/1ps
`default_nettype none

// First-word fall-through header FIFO, loaded by the testbench before each packet
module hdr_fifo_model (
	input wire clk,
	input wire rd_en,
	output rd_fill_pkg::word_t dout,
	output logic empty
);

	rd_fill_pkg::word_t entries [8];
	int head = 0;
	int count = 0;
	// Pops seen since the last clear
	int pops = 0;

	// Head word shows whenever the FIFO holds something
	assign dout = entries[head];
	assign empty = (count == 0);

	task automatic clear();
		head = 0;
		count = 0;
		pops = 0;
	endtask

	task automatic load(input rd_fill_pkg::word_t w);
		entries[head + count] = w;
		count = count + 1;
	endtask

	always @(posedge clk) begin
		if (rd_en && count > 0) begin
			head <= head + 1;
			count <= count - 1;
			pops <= pops + 1;
		end
	end

endmodule

// Buffer memory, read data appears MEM_LATENCY cycles after the address
module buffer_mem_model (
	input wire clk,
	input wire rd_fill_pkg::addr_t addr,
	output rd_fill_pkg::word_t rdata
);

	rd_fill_pkg::word_t image [64];
	rd_fill_pkg::word_t pipe [rd_fill_pkg::MEM_LATENCY];

	task automatic load_word(input int idx, input rd_fill_pkg::word_t w);
		image[idx] = w;
	endtask

	// Image is 64 words deep, upper address bits wrap
	always @(posedge clk) begin
		pipe[0] <= image[addr[5:0]];
		for (int i = 1; i < rd_fill_pkg::MEM_LATENCY; i++) begin
			pipe[i] <= pipe[i-1];
		end
	end

	assign rdata = pipe[rd_fill_pkg::MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: rtl/rd_fill_top.sv
`timescale 1ns/1ps
`default_nettype none

// Read-fill responder, sequencer plus memory reader
module rd_fill_top (
	input wire clk,
	input wire rst,
	// Command dispatcher
	input wire run,
	input wire rd_fill_pkg::word_t csn,
	input wire rd_fill_pkg::word_t cmd_code,
	output wire busy,
	output wire done,
	// Transmit stream
	output wire tx_tvalid,
	output wire rd_fill_pkg::word_t tx_tdata,
	output wire tx_tlast,
	input wire tx_tready,
	// Header FIFO, first-word fall-through
	input wire rd_fill_pkg::word_t hdr_dout,
	input wire hdr_empty,
	output wire hdr_rd_en,
	// Buffer memory read port
	output wire rd_fill_pkg::addr_t mem_addr,
	input wire rd_fill_pkg::word_t mem_rdata
);

	// Burst handshake between the two blocks
	fill_read_if rd_if ();

	rd_fill_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.run(run),
		.csn(csn),
		.cmd_code(cmd_code),
		.tx_tready(tx_tready),
		.hdr_dout(hdr_dout),
		.hdr_empty(hdr_empty),
		.busy(busy),
		.done(done),
		.tx_tvalid(tx_tvalid),
		.tx_tdata(tx_tdata),
		.tx_tlast(tx_tlast),
		.hdr_rd_en(hdr_rd_en),
		.rd(rd_if)
	);

	// Memory reader owns the address bus
	fill_data_reader u_reader (
		.clk(clk),
		.rst(rst),
		.mem_rdata(mem_rdata),
		.mem_addr(mem_addr),
		.rd(rd_if)
	);

endmodule

`default_nettype wire

// File: rtl/fill_data_reader.sv
`timescale 1ns/1ps
`default_nettype none

// Reads one burst from the buffer memory under a credit limit
module fill_data_reader (
	input wire clk,
	input wire rst,
	input wire rd_fill_pkg::word_t mem_rdata,
	output rd_fill_pkg::addr_t mem_addr,
	fill_read_if.reader rd
);

	rd_fill_pkg::addr_t addr_q;
	rd_fill_pkg::addr_t addr_cur;
	rd_fill_pkg::count_t remain_q;
	rd_fill_pkg::count_t remain_cur;
	logic [$clog2(rd_fill_pkg::READ_CREDITS+1)-1:0] credits_q;
	logic [$clog2(rd_fill_pkg::READ_CREDITS+1)-1:0] credits_cur;
	logic [$clog2(rd_fill_pkg::READ_CREDITS+1)-1:0] credits_d;
	logic [rd_fill_pkg::MEM_LATENCY-1:0] tag_q;
	rd_fill_pkg::word_t buf_mem [rd_fill_pkg::READ_CREDITS];
	logic [$clog2(rd_fill_pkg::READ_CREDITS)-1:0] wr_ptr_q;
	logic [$clog2(rd_fill_pkg::READ_CREDITS)-1:0] rd_ptr_q;
	logic [$clog2(rd_fill_pkg::READ_CREDITS+1)-1:0] fill_q;
	rd_fill_pkg::word_t head;
	rd_fill_pkg::word_t checksum_q;
	logic done_q;
	logic issue;
	logic push;
	logic accept;

	// Start cycle already issues from the new base, and drops any stale credits
	assign addr_cur = rd.start ? rd.base_addr : addr_q;
	assign remain_cur = rd.start ? rd.word_count : remain_q;
	assign credits_cur = rd.start ? '0 : credits_q;

	assign issue = (remain_cur != '0) && (credits_cur < rd_fill_pkg::READ_CREDITS);
	assign mem_addr = addr_cur;

	// Word returning from memory this cycle
	assign push = tag_q[rd_fill_pkg::MEM_LATENCY-1];
	assign accept = rd.data_valid && rd.data_ready;

	// Credit taken at issue, returned when the sequencer takes a word
	always_comb begin
		credits_d = credits_cur;
		if (issue && !accept) credits_d = credits_cur + 1'b1;
		else if (!issue && accept) credits_d = credits_cur - 1'b1;
	end

	// Address and remaining-word counters
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q <= '0;
			remain_q <= '0;
			credits_q <= '0;
		end else begin
			addr_q <= issue ? addr_cur + 1'b1 : addr_cur;
			remain_q <= issue ? remain_cur - 1'b1 : remain_cur;
			credits_q <= credits_d;
		end
	end

	// Read tags follow each issue through the memory pipeline
	always_ff @(posedge clk) begin
		if (rst) tag_q <= '0;
		else if (rd.start) tag_q <= {{(rd_fill_pkg::MEM_LATENCY-1){1'b0}}, issue};
		else tag_q <= {tag_q[rd_fill_pkg::MEM_LATENCY-2:0], issue};
	end

	// Output buffer pointers, depth is a power of two so they wrap on their own
	always_ff @(posedge clk) begin
		if (rst || rd.start) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			fill_q <= '0;
		end else begin
			if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (accept) rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({push, accept})
				2'b10: fill_q <= fill_q + 1'b1;
				2'b01: fill_q <= fill_q - 1'b1;
				default: fill_q <= fill_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) buf_mem[wr_ptr_q] <= mem_rdata;
	end

	assign head = buf_mem[rd_ptr_q];

	// Running XOR of accepted words
	always_ff @(posedge clk) begin
		if (rd.start) checksum_q <= '0;
		else if (accept) checksum_q <= checksum_q ^ head;
	end

	// Burst complete once nothing remains, is in flight or is buffered
	always_ff @(posedge clk) begin
		if (rst) done_q <= 1'b0;
		else if (rd.start) done_q <= (rd.word_count == '0);
		else if (remain_q == '0 && credits_d == '0) done_q <= 1'b1;
	end

	assign rd.data_valid = (fill_q != '0);
	assign rd.data = head;
	assign rd.burst_done = done_q;
	assign rd.checksum = checksum_q;

	// Credits bound the reads in flight plus the buffered words
	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits_q <= rd_fill_pkg::READ_CREDITS);

	// burst_done only after the memory pipeline and buffer have drained
	a_done_drained: assert property (@(posedge clk) disable iff (rst)
		$rose(rd.burst_done) |-> (tag_q == '0) && (fill_q == '0));

endmodule

`default_nettype wire

// File: rtl/rd_fill_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Packet FSM for the read-fill response
module rd_fill_sequencer (
	input wire clk,
	input wire rst,
	input wire run,
	input wire rd_fill_pkg::word_t csn,
	input wire rd_fill_pkg::word_t cmd_code,
	input wire tx_tready,
	input wire rd_fill_pkg::word_t hdr_dout,
	input wire hdr_empty,
	output logic busy,
	output logic done,
	output logic tx_tvalid,
	output rd_fill_pkg::word_t tx_tdata,
	output logic tx_tlast,
	output logic hdr_rd_en,
	fill_read_if.sequencer rd
);

	// Packet phases
	enum logic [3:0] {
		S_IDLE, S_CHK_TRIG, S_GET_TRIG, S_CHK_SIZE,
		S_GET_SIZE, S_SEND_CSN, S_SEND_CMD, S_SEND_TRIG,
		S_SEND_SIZE, S_SEND_CHAN, S_SEND_POST, S_START,
		S_DATA, S_SEND_SUM, S_DONE, S_WAIT
	} state_q, state_d;

	logic error_q;
	rd_fill_pkg::word_t trig_q;
	rd_fill_pkg::word_t size_q;
	logic word_state;
	logic word_ok;
	logic word_last;
	rd_fill_pkg::word_t word_data;
	logic accepted;
	logic take;
	logic load;

	// Word leaves the output register on this edge
	assign accepted = tx_tvalid && tx_tready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: if (run) state_d = S_CHK_TRIG;
			// Empty FIFO at either check goes straight to the short error packet
			S_CHK_TRIG: state_d = hdr_empty ? S_SEND_CSN : S_GET_TRIG;
			S_GET_TRIG: state_d = S_CHK_SIZE;
			S_CHK_SIZE: state_d = hdr_empty ? S_SEND_CSN : S_GET_SIZE;
			S_GET_SIZE: state_d = S_SEND_CSN;
			S_SEND_CSN: if (accepted) state_d = S_SEND_CMD;
			S_SEND_CMD: if (accepted) state_d = error_q ? S_DONE : S_SEND_TRIG;
			S_SEND_TRIG: if (accepted) state_d = S_SEND_SIZE;
			S_SEND_SIZE: if (accepted) state_d = S_SEND_CHAN;
			S_SEND_CHAN: if (accepted) state_d = S_SEND_POST;
			S_SEND_POST: if (accepted) state_d = S_START;
			// Start address word must be at the FIFO head
			S_START: if (!hdr_empty) state_d = S_DATA;
			// Leave once the last data word has left the output register
			S_DATA: if (rd.burst_done && (!tx_tvalid || tx_tready)) state_d = S_SEND_SUM;
			S_SEND_SUM: if (accepted) state_d = S_DONE;
			S_DONE: state_d = S_WAIT;
			// Held here until the dispatcher drops run
			S_WAIT: state_d = S_WAIT;
			default: state_d = S_IDLE;
		endcase
		// Dropping run aborts from any phase
		if (!run) state_d = S_IDLE;
	end

	always_ff @(posedge clk) begin
		if (rst) state_q <= S_IDLE;
		else state_q <= state_d;
	end

	// Error flag, set on an empty FIFO at either check
	always_ff @(posedge clk) begin
		if (rst) begin
			error_q <= 1'b0;
		end else if (state_q == S_IDLE) begin
			error_q <= 1'b0;
		end else if ((state_q == S_CHK_TRIG || state_q == S_CHK_SIZE) && hdr_empty) begin
			error_q <= 1'b1;
		end
	end

	// Header capture, one cycle each
	always_ff @(posedge clk) begin
		if (state_q == S_GET_TRIG) trig_q <= hdr_dout;
		if (state_q == S_GET_SIZE) size_q <= hdr_dout;
	end

	// Response word mux for the non-data phases
	always_comb begin
		word_state = 1'b1;
		word_ok = 1'b1;
		word_last = 1'b0;
		word_data = csn;
		case (state_q)
			S_SEND_CSN: word_data = csn;
			S_SEND_CMD: begin
				// inverse code marks the error packet
				word_data = error_q ? ~cmd_code : cmd_code;
				word_last = error_q;
			end
			S_SEND_TRIG: word_data = trig_q;
			S_SEND_SIZE: word_data = size_q;
			// Channel and post-trigger words come straight off the FIFO head
			S_SEND_CHAN, S_SEND_POST: begin
				word_data = hdr_dout;
				word_ok = !hdr_empty;
			end
			S_SEND_SUM: begin
				word_data = rd.checksum;
				word_last = 1'b1;
			end
			default: word_state = 1'b0;
		endcase
	end

	// Reader is stalled whenever the output register cannot take a word
	assign rd.data_ready = (state_q == S_DATA) && (!tx_tvalid || tx_tready);
	assign take = rd.data_valid && rd.data_ready;

	// Header words load into an empty register, data words at full rate
	assign load = take || (word_state && word_ok && !tx_tvalid);

	// Stream output register
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_tvalid <= 1'b0;
			tx_tlast <= 1'b0;
		end else if (!run) begin
			tx_tvalid <= 1'b0;
			tx_tlast <= 1'b0;
		end else begin
			if (tx_tready) begin
				tx_tvalid <= 1'b0;
				tx_tlast <= 1'b0;
			end
			if (load) begin
				tx_tvalid <= 1'b1;
				tx_tlast <= take ? 1'b0 : word_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) tx_tdata <= take ? rd.data : word_data;
	end

	// Burst request, start address taken from the FIFO head
	assign rd.start = (state_q == S_START) && !hdr_empty;
	assign rd.base_addr = hdr_dout[rd_fill_pkg::ADDR_W-1:0];
	assign rd.word_count = size_q[rd_fill_pkg::ADDR_W-1:0];

	// Pops: two captures, two accepted header words, one start address
	assign hdr_rd_en = (state_q == S_GET_TRIG) || (state_q == S_GET_SIZE) ||
		((state_q == S_SEND_CHAN || state_q == S_SEND_POST) && accepted) ||
		rd.start;

	assign busy = (state_q != S_IDLE);
	assign done = (state_q == S_DONE);

	// A presented word holds until taken, unless the packet is aborted
	a_tx_hold: assert property (@(posedge clk) disable iff (rst || !run)
		tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast));

	// Never pop an empty header FIFO
	a_pop_nonempty: assert property (@(posedge clk) disable iff (rst)
		!(hdr_rd_en && hdr_empty));

endmodule

`default_nettype wire

// File: rtl/fill_read_if.sv
`timescale 1ns/1ps
`default_nettype none

// One data burst between the packet sequencer and the memory reader
interface fill_read_if;

	// Burst request, start is a single-cycle pulse
	logic start;
	rd_fill_pkg::addr_t base_addr;
	rd_fill_pkg::count_t word_count;

	// Data words, same valid/ready rule as the external stream
	logic data_valid;
	rd_fill_pkg::word_t data;
	logic data_ready;

	// Burst status, checksum only valid while burst_done is high
	logic burst_done;
	rd_fill_pkg::word_t checksum;

	modport sequencer (
		output start, base_addr, word_count, data_ready,
		input data_valid, data, burst_done, checksum
	);

	modport reader (
		input start, base_addr, word_count, data_ready,
		output data_valid, data, burst_done, checksum
	);

endinterface

`default_nettype wire

// File: rtl/rd_fill_pkg.sv
`default_nettype none

// Shared widths, word types and memory timing for the read-fill responder
package rd_fill_pkg;

	// Stream, header and memory words are all one width
	localparam int DATA_W = 32;

	// Buffer memory depth is 4K words
	localparam int ADDR_W = 12;

	// One data word on any of the three paths
	typedef logic [DATA_W-1:0] word_t;

	// Buffer memory address
	typedef logic [ADDR_W-1:0] addr_t;

	// Word count for one burst, low bits of the buffer-size header word
	typedef logic [ADDR_W-1:0] count_t;

	// Cycles from mem_addr to mem_rdata, no read enable on the memory
	localparam int MEM_LATENCY = 2;

	// Reads issued but not yet taken by the sequencer
	// matches the depth of the reader output buffer
	localparam int READ_CREDITS = 2;

endpackage

`default_nettype wire
